// File: hdl/spi_reg_pkg.sv
package spi_reg_pkg;

    typedef logic [31:0] data_t;  // Bus data word
    typedef logic [7:0]  addr_t;  // Register address from the address byte
    typedef logic [7:0]  byte_t;  // One UART character

    // Serial protocol bytes
    localparam byte_t OP_WRITE = 8'h57;  // 'W'
    localparam byte_t OP_READ  = 8'h52;  // 'R'
    localparam byte_t ACK_BYTE = 8'h2B;  // '+' write done
    localparam byte_t NAK_BYTE = 8'h3F;  // '?' unknown opcode

    localparam data_t BAD_ADDR_DATA  = 32'hBAD0_ADD5;  // Unmapped read value
    localparam int    BYTES_PER_WORD = 4;              // Bytes per word on the link

    // Command server states
    typedef enum logic [2:0] {
        IDLE,      // Waiting for opcode
        GET_ADDR,  // Waiting for address byte
        GET_DATA,  // Collecting write data
        BUS_WR,    // Write strobe cycle
        BUS_RD,    // Read strobe cycle
        WAIT_RD,   // Waiting for decoder read data
        SEND       // Reply bytes out
    } srv_state_t;

endpackage

// File: hdl/opb_if.sv
`timescale 1ns/1ps

// Simple OPB style register bus
interface opb_if;
    import spi_reg_pkg::*;

    addr_t addr;   // Register address
    data_t wdata;  // Write data
    logic  re;     // One-cycle read strobe
    logic  we;     // One-cycle write strobe

    // Command server side
    modport master (output addr, output wdata, output re, output we);

    // Address decoder sees the whole bus
    modport decoder (input addr, input wdata, input re, input we);

    // Register bank only needs the write data
    modport target (input wdata);

endinterface

// File: hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 87
) (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic               uart_rxd,
    output spi_reg_pkg::byte_t rx_data,
    output logic               rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);        // End of bit
    localparam logic [CNT_W-1:0] HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);  // Mid-bit point

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic [2:0]       sync;     // Two sync flops plus one history flop
    logic [CNT_W-1:0] cnt;      // Clocks within the current bit
    logic [2:0]       bit_idx;  // Data bit number
    logic             line;     // Synchronised line level
    logic             bit_end;

    assign line    = sync[1];
    assign bit_end = (cnt == LAST);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            sync     <= 3'b111;  // Line idles high
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync     <= {sync[1:0], uart_rxd};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (sync[2] && !line) begin  // Falling start edge
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == HALF) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= line ? RX_IDLE : RX_DATA;  // Glitch rejected
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cnt      <= '0;
                        rx_valid <= line;  // Low stop bit drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first into the top of the shifter
    always_ff @(posedge sys_clk) begin
        if (state == RX_DATA && bit_end) begin
            rx_data <= {line, rx_data[7:1]};
        end
    end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 87
) (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic               tx_start,
    input  spi_reg_pkg::byte_t tx_data,
    output logic               uart_txd,
    output logic               tx_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);  // Last clock of a bit

    logic [9:0]       frame;    // Stop, data, start
    logic [CNT_W-1:0] cnt;      // Clocks within the current bit
    logic [3:0]       bit_idx;  // Bit of the frame on the line

    assign uart_txd = frame[0];

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            frame   <= '1;  // Idle high
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame   <= {1'b1, tx_data, 1'b0};  // 8N1 frame
                tx_busy <= 1'b1;
                cnt     <= '0;
                bit_idx <= '0;
            end
        end else if (cnt == LAST) begin
            cnt   <= '0;
            frame <= {1'b1, frame[9:1]};  // Ones fill behind the stop bit
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;  // Stop bit done
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: hdl/cmd_server.sv
`timescale 1ns/1ps

module cmd_server (
    input  logic               sys_clk,
    input  logic               rst,
    input  spi_reg_pkg::byte_t rx_data,
    input  logic               rx_valid,
    output spi_reg_pkg::byte_t tx_data,
    output logic               tx_start,
    input  logic               tx_busy,
    opb_if.master              bus,
    input  spi_reg_pkg::data_t rd_data,
    input  logic               rd_valid
);
    import spi_reg_pkg::*;

    localparam int CNT_W = $clog2(BYTES_PER_WORD + 1);

    srv_state_t       state;
    logic             is_wr;     // Current command is a write
    logic [CNT_W-1:0] byte_cnt;  // Data bytes in or reply bytes left
    addr_t            addr_q;
    data_t            word;      // Write data then reply bytes
    logic             send_ok;   // Transmitter free for the next byte
    logic             last_data;
    logic             known_op;

    assign send_ok   = (state == SEND) && !tx_busy && !tx_start;
    assign last_data = (byte_cnt == CNT_W'(BYTES_PER_WORD - 1));
    assign known_op  = (rx_data == OP_WRITE) || (rx_data == OP_READ);

    // Strobes straight from state so each lasts one cycle
    assign bus.addr  = addr_q;
    assign bus.wdata = word;
    assign bus.we    = (state == BUS_WR);
    assign bus.re    = (state == BUS_RD);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state    <= IDLE;
            is_wr    <= 1'b0;
            byte_cnt <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= send_ok;
            case (state)
                IDLE: begin
                    if (rx_valid) begin
                        is_wr <= (rx_data == OP_WRITE);
                        if (known_op) begin
                            state <= GET_ADDR;
                        end else begin
                            byte_cnt <= CNT_W'(1);  // Single NAK byte
                            state    <= SEND;
                        end
                    end
                end
                GET_ADDR: begin
                    if (rx_valid) begin
                        byte_cnt <= '0;
                        state    <= is_wr ? GET_DATA : BUS_RD;
                    end
                end
                GET_DATA: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (last_data) begin
                            state <= BUS_WR;
                        end
                    end
                end
                BUS_WR: begin
                    byte_cnt <= CNT_W'(1);  // Single ACK byte
                    state    <= SEND;
                end
                BUS_RD: state <= WAIT_RD;
                WAIT_RD: begin
                    if (rd_valid) begin
                        byte_cnt <= CNT_W'(BYTES_PER_WORD);  // Whole word back
                        state    <= SEND;
                    end
                end
                SEND: begin
                    if (send_ok) begin
                        byte_cnt <= byte_cnt - 1'b1;
                        if (byte_cnt == CNT_W'(1)) begin
                            state <= IDLE;  // Last byte handed over
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and data path
    always_ff @(posedge sys_clk) begin
        case (state)
            IDLE:     if (rx_valid) word <= {NAK_BYTE, 24'h0};
            GET_ADDR: if (rx_valid) addr_q <= rx_data;
            GET_DATA: if (rx_valid) word <= {word[23:0], rx_data};  // MSB first
            BUS_WR:   word <= {ACK_BYTE, 24'h0};  // Kept until the strobe ends
            WAIT_RD:  if (rd_valid) word <= rd_data;
            SEND: begin
                if (send_ok) begin
                    tx_data <= word[31:24];
                    word    <= {word[23:0], 8'h0};
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/address_decode.sv
`timescale 1ns/1ps

module address_decode #(
    parameter int NUM_SP_REGS = 2
) (
    input  logic                   sys_clk,
    input  logic                   rst,
    opb_if.decoder                 bus,
    output logic [NUM_SP_REGS-1:0] sp_we,
    input  spi_reg_pkg::data_t     sp_q [NUM_SP_REGS],
    output spi_reg_pkg::data_t     rd_data,
    output logic                   rd_valid
);
    import spi_reg_pkg::*;

    localparam int SEL_W = (NUM_SP_REGS > 1) ? $clog2(NUM_SP_REGS) : 1;

    logic             in_range;  // Address hits the scratchpad
    logic [SEL_W-1:0] sel;       // Register index

    assign in_range = (int'(bus.addr) < NUM_SP_REGS);
    assign sel      = bus.addr[SEL_W-1:0];

    // Write strobes follow we in the same cycle
    always_comb begin
        sp_we = '0;
        if (bus.we && in_range) begin
            sp_we[sel] = 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= bus.re;  // One cycle behind re
        end
    end

    // Registered read mux
    always_ff @(posedge sys_clk) begin
        if (bus.re) begin
            rd_data <= in_range ? sp_q[sel] : BAD_ADDR_DATA;
        end
    end

endmodule

// File: hdl/scratch_pad.sv
`timescale 1ns/1ps

module scratch_pad #(
    parameter int NUM_SP_REGS = 2
) (
    input  logic                   sys_clk,
    input  logic                   rst,
    opb_if.target                  bus,
    input  logic [NUM_SP_REGS-1:0] sp_we,
    output spi_reg_pkg::data_t     sp_q [NUM_SP_REGS]
);

    // One word per register
    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < NUM_SP_REGS; i++) begin
            if (rst) begin
                sp_q[i] <= '0;  // Readable as zero after reset
            end else if (sp_we[i]) begin
                sp_q[i] <= bus.wdata;
            end
        end
    end

endmodule

// File: hdl/top.sv
`timescale 1ns/1ps

module top #(
    parameter int CLKS_PER_BIT = 87,
    parameter int NUM_SP_REGS  = 2
) (
    input  logic sys_clk,
    input  logic rst,
    input  logic uart_rxd,
    output logic uart_txd
);
    import spi_reg_pkg::*;

    byte_t                  rx_data;   // Received byte
    logic                   rx_valid;
    byte_t                  tx_data;   // Reply byte
    logic                   tx_start;
    logic                   tx_busy;
    logic [NUM_SP_REGS-1:0] sp_we;     // Per register write strobes
    data_t                  sp_q [NUM_SP_REGS];
    data_t                  rd_data;   // Decoder read data
    logic                   rd_valid;

    opb_if bus ();  // Register bus

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_0 (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .uart_rxd (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_0 (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .uart_txd (uart_txd),
        .tx_busy  (tx_busy)
    );

    cmd_server cmd_server_0 (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .bus      (bus.master),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    address_decode #(.NUM_SP_REGS(NUM_SP_REGS)) address_decode_0 (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .bus      (bus.decoder),
        .sp_we    (sp_we),
        .sp_q     (sp_q),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    scratch_pad #(.NUM_SP_REGS(NUM_SP_REGS)) scratch_pad_0 (
        .sys_clk (sys_clk),
        .rst     (rst),
        .bus     (bus.target),
        .sp_we   (sp_we),
        .sp_q    (sp_q)
    );

endmodule

// File: dv/top_assert.sv
`timescale 1ns/1ps

module top_assert (
    input logic sys_clk,
    input logic rst,
    input logic re,
    input logic we,
    input logic rd_valid,
    input logic uart_txd,
    input logic tx_busy,
    input logic tx_start
);

    // Bus strobes are exclusive
    strobes_exclusive: assert property (@(posedge sys_clk) disable iff (rst) !(re && we))
        else $error("re and we high in the same cycle");

    read_data_follows: assert property (@(posedge sys_clk) disable iff (rst) re |=> rd_valid)
        else $error("rd_valid missing one cycle after re");

    no_stray_rd_valid: assert property (@(posedge sys_clk) disable iff (rst)
                                        rd_valid |-> $past(re))
        else $error("rd_valid without re in the cycle before");

    // Line idles high between frames
    idle_line_high: assert property (@(posedge sys_clk) disable iff (rst) !tx_busy |-> uart_txd)
        else $error("uart_txd low while the transmitter is idle");

    start_when_free: assert property (@(posedge sys_clk) disable iff (rst) tx_busy |-> !tx_start)
        else $error("tx_start raised while the transmitter is busy");

endmodule

bind top top_assert top_assert_0 (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .re       (bus.re),
    .we       (bus.we),
    .rd_valid (rd_valid),
    .uart_txd (uart_txd),
    .tx_busy  (tx_busy),
    .tx_start (tx_start)
);

// File: dv/top_tb.sv
`timescale 1ns/1ps

module top_tb;

    localparam int CLKS_PER_BIT = 8;
    localparam int NUM_REGS     = 4;
    localparam int CLK_PERIOD   = 100;
    localparam int TEST_BYTES   = 161;  // Command and reply bytes of all tests
    localparam int WATCHDOG_NS  = TEST_BYTES * 10 * CLKS_PER_BIT * CLK_PERIOD * 4;

    localparam logic [7:0]  CMD_W    = 8'h57;
    localparam logic [7:0]  CMD_R    = 8'h52;
    localparam logic [7:0]  ACK      = 8'h2B;
    localparam logic [7:0]  NAK      = 8'h3F;
    localparam logic [31:0] BAD_WORD = 32'hBAD0_ADD5;  // Unmapped read value

    logic        sys_clk;
    logic        rst;
    logic        uart_rxd;
    logic        uart_txd;
    logic [31:0] lfsr_state = 32'h495919e1;
    logic [31:0] model_regs [NUM_REGS];  // Expected register contents
    logic [7:0]  exp_q [$];              // Reply bytes still expected
    logic [7:0]  reply_q [$];            // Bytes seen on uart_txd
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run   = 0;
    int          bad_tests   = 0;

    top #(.CLKS_PER_BIT(CLKS_PER_BIT), .NUM_SP_REGS(NUM_REGS)) UUT (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};  // One step per bit
        end
        return v;
    endfunction

    // Register bank model that queues the reply bytes a command should produce
    function automatic void expect_reply(input logic [7:0] op, input logic [7:0] addr,
                                         input logic [31:0] data);
        logic [31:0] word;
        word = BAD_WORD;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (int'(addr) == i) begin
                word = model_regs[i];
                if (op == CMD_W) model_regs[i] = data;
            end
        end
        if (op == CMD_W) begin
            exp_q.push_back(ACK);  // Acked even when unmapped
        end else if (op == CMD_R) begin
            for (int i = 3; i >= 0; i--) exp_q.push_back(word[i*8 +: 8]);  // MSB first
        end else begin
            exp_q.push_back(NAK);
        end
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // 8N1 frame with each bit held for CLKS_PER_BIT falling edges
    task automatic send_byte(input logic [7:0] b, input logic stop);
        logic [9:0] frame;
        frame = {stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge sys_clk);
            uart_rxd = frame[i];
            repeat (CLKS_PER_BIT - 1) @(negedge sys_clk);
        end
    endtask

    task automatic run_cmd(input logic [7:0] op, input logic [7:0] addr,
                           input logic [31:0] data);
        expect_reply(op, addr, data);
        send_byte(op, 1'b1);
        if (op == CMD_W || op == CMD_R) send_byte(addr, 1'b1);
        if (op == CMD_W) begin
            for (int i = 3; i >= 0; i--) send_byte(data[i*8 +: 8], 1'b1);
        end
        while (exp_q.size() != 0) @(negedge sys_clk);  // Reply fully received
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("[%0t] %s: OK", $time, name);
        end else begin
            bad_tests++;
            $display("[%0t] %s: %0d errors", $time, name, error_count - errors_before);
        end
    endtask

    // Decode uart_txd by sampling mid-bit on falling clock edges
    initial begin : reply_monitor
        logic [7:0] b;
        @(negedge rst);
        forever begin
            @(negedge uart_txd);  // Start bit
            repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge sys_clk);
                b[i] = uart_txd;
            end
            repeat (CLKS_PER_BIT) @(negedge sys_clk);
            if (uart_txd !== 1'b1) begin
                error_count++;
                $display("Reply byte %h at %0t has a low stop bit", b, $time);
            end
            reply_q.push_back(b);
        end
    end

    initial begin : compare_replies
        logic [7:0] got;
        forever begin
            @(negedge sys_clk);
            while (reply_q.size() != 0) begin
                got = reply_q.pop_front();
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Reply byte %h at %0t arrived when none was expected", got, $time);
                end else begin
                    check_val("uart_txd_byte", 32'(got), 32'(exp_q.pop_front()));
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout at %0t, the DUT stopped replying", $time);
        $display("test failed");
        $finish;
    end

    initial begin : stimulus
        int errs;
        int order [NUM_REGS];
        int j;
        int tmp;
        rst      = 1'b1;
        uart_rxd = 1'b1;  // Line idle
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
        repeat (5) @(negedge sys_clk);
        rst = 1'b0;

        errs = error_count;
        for (int i = 0; i < NUM_REGS; i++) run_cmd(CMD_R, 8'(i), '0);
        finish_test("reset_state", errs);

        errs = error_count;
        run_cmd(CMD_W, 8'd2, 32'h1234_5678);
        run_cmd(CMD_R, 8'd2, '0);
        finish_test("write_read_back", errs);

        errs = error_count;
        for (int i = 0; i < NUM_REGS; i++) run_cmd(CMD_W, 8'(i), rand_bits(32));
        for (int i = 0; i < NUM_REGS; i++) order[i] = i;
        for (int i = NUM_REGS - 1; i > 0; i--) begin  // Shuffle the read order
            j        = int'(rand_bits(8)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < NUM_REGS; i++) run_cmd(CMD_R, 8'(order[i]), '0);
        finish_test("independent_regs", errs);

        errs = error_count;
        run_cmd(CMD_R, 8'(NUM_REGS), '0);
        run_cmd(CMD_R, 8'hFF, '0);
        run_cmd(CMD_W, 8'(NUM_REGS), rand_bits(32));  // Must not land anywhere
        for (int i = 0; i < NUM_REGS; i++) run_cmd(CMD_R, 8'(i), '0);
        finish_test("unmapped_addr", errs);

        errs = error_count;
        run_cmd(8'hA5, '0, '0);
        run_cmd(CMD_W, 8'd0, rand_bits(32));
        run_cmd(CMD_R, 8'd0, '0);
        finish_test("unknown_opcode", errs);

        errs = error_count;
        send_byte(CMD_R, 1'b0);  // Framing error that the receiver drops
        @(negedge sys_clk);
        uart_rxd = 1'b1;
        repeat (2 * CLKS_PER_BIT) @(negedge sys_clk);  // Idle so the next start edge shows
        run_cmd(CMD_W, 8'd3, rand_bits(32));
        run_cmd(CMD_R, 8'd3, '0);
        finish_test("bad_stop_bit", errs);

        repeat (20 * CLKS_PER_BIT) @(negedge sys_clk);  // Catch stray reply bytes
        $display("tests=%0d failing=%0d checks=%0d errors=%0d",
                 tests_run, bad_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/spi_reg_pkg.sv
hdl/opb_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_server.sv
hdl/address_decode.sv
hdl/scratch_pad.sv
hdl/top.sv
dv/top_assert.sv
dv/top_tb.sv

// File: Makefile
# Verilator build and run of the serial register core testbench

VERILATOR ?= verilator
TOP       ?= top_tb
BUILD_DIR ?= build
FILELIST  ?= sources.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)
